/* source/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// bit period divisor, one bit lasts divisor plus one clocks
`define UART_DIV_W 16

// width of one data character
`define UART_DATA_W 8

// shift register length
// start, eight data, ninth and stop bits
`define UART_FRAME_W 11

`endif

/* source/uart_ctrl_pkg.sv */
package uart_ctrl_pkg;

    // control word bit positions
    localparam int CTL_MODE_LO  = 0;
    localparam int CTL_MODE_HI  = 1;
    localparam int CTL_HUNT_VAL = 2;
    localparam int CTL_DISCARD  = 3;
    localparam int CTL_RX_EN    = 4;
    localparam int CTL_HUNT_EN  = 5;
    localparam int CTL_TX_EN    = 6;
    localparam int CTL_TX_NINTH = 7;

    // ninth-bit modes
    localparam logic [1:0] MODE_EIGHT      = 2'b00;
    localparam logic [1:0] MODE_ODD        = 2'b01;
    localparam logic [1:0] MODE_EVEN       = 2'b10;
    localparam logic [1:0] MODE_NINTH_DATA = 2'b11;

    // status word bit positions, bit 7 reads zero
    localparam int ST_RX_AVAIL = 0;
    localparam int ST_TX_ROOM  = 1;
    localparam int ST_NOISE    = 2;
    localparam int ST_FRAMING  = 3;
    localparam int ST_PARITY   = 4;
    localparam int ST_OVERRUN  = 5;
    localparam int ST_NINTH    = 6;

    // any mode except plain eight bits carries a ninth bit
    function automatic logic nine_bit_mode(input logic [1:0] mode);
        return mode != MODE_EIGHT;
    endfunction

endpackage

/* source/uart_frame_pkg.sv */
`include "uart_cfg.svh"

package uart_frame_pkg;

    import uart_ctrl_pkg::*;

    // ninth bit to send for a character
    // in eight-bit mode the slot becomes a second stop bit
    function automatic logic tx_ninth_bit(input logic [1:0] mode,
                                          input logic [`UART_DATA_W-1:0] data,
                                          input logic ninth_ctl);
        case (mode)
            MODE_EIGHT: return 1'b1;
            MODE_ODD:   return ~^data;
            MODE_EVEN:  return ^data;
            default:    return ninth_ctl;
        endcase
    endfunction

    // parity check over data and ninth bit, only in the parity modes
    function automatic logic rx_parity_bad(input logic [1:0] mode,
                                           input logic [`UART_DATA_W:0] bits);
        case (mode)
            MODE_ODD:  return ~^bits;
            MODE_EVEN: return ^bits;
            default:   return 1'b0;
        endcase
    endfunction

    // address filter for multiprocessor mode
    function automatic logic hunt_match(input logic [7:0] control, input logic ninth);
        logic hunting;
        hunting = control[CTL_HUNT_EN] &&
                  (control[CTL_MODE_HI:CTL_MODE_LO] == MODE_NINTH_DATA);
        return !hunting || (ninth == control[CTL_HUNT_VAL]);
    endfunction

endpackage

/* source/uart_rx_frontend.sv */
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_frontend (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rxd,
    input  logic [7:0]             control,
    input  logic [`UART_DIV_W-1:0] baudrate,
    input  logic                   stage_full,
    output logic                   frame_strobe,
    output logic [`UART_DATA_W:0]  frame_bits,
    output logic                   frame_noise,
    output logic                   frame_framing,
    output logic                   frame_overrun
);

    import uart_ctrl_pkg::*;

    logic                     rxd_meta;
    logic                     rxd_sync;
    logic                     rxd_last;
    logic                     rxd_filt;
    logic                     bit_noise;
    logic                     rx_active;
    logic                     rx_first;
    logic                     rx_noise;
    logic                     hold_idle;
    logic [`UART_DIV_W-1:0]   rx_cnt;
    logic [`UART_DIV_W-1:0]   mid_cnt;
    logic [`UART_FRAME_W-1:0] rx_sr;
    logic                     nine_mode;
    logic                     sample_hi;
    logic                     sample_lo;
    logic                     mid_bit;
    logic                     shift_bit;
    logic                     start_det;
    logic                     sr_in;

    assign nine_mode = nine_bit_mode(control[CTL_MODE_HI:CTL_MODE_LO]);

    // two equal samples in a row decide the level
    assign sample_hi = rxd_last && rxd_sync;
    assign sample_lo = !rxd_last && !rxd_sync;

    assign mid_cnt   = {1'b0, baudrate[`UART_DIV_W-1:1]} + 1'b1;
    assign mid_bit   = rx_active && (rx_cnt == mid_cnt);
    assign shift_bit = rx_active && (rx_cnt == mid_cnt + 1'b1);
    assign start_det = control[CTL_RX_EN] && !rx_active && !hold_idle && sample_lo;

    // the first shift plants the start marker instead of the sample
    assign sr_in = rx_first ? 1'b0 : rxd_filt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_last <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_last <= rxd_sync;
        end
    end

    // mid-bit majority, keeps the old level when the samples disagree
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_filt  <= 1'b1;
            bit_noise <= 1'b0;
        end else if (mid_bit) begin
            rxd_filt  <= sample_hi ? 1'b1 : (sample_lo ? 1'b0 : rxd_filt);
            bit_noise <= !sample_hi && !sample_lo;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_active <= 1'b0;
            rx_cnt    <= '0;
        end else if (!control[CTL_RX_EN] || frame_strobe) begin
            rx_active <= 1'b0;
            rx_cnt    <= '0;
        end else if (start_det) begin
            rx_active <= 1'b1;
            rx_cnt    <= '0;
        end else if (rx_active) begin
            rx_cnt <= (rx_cnt >= baudrate) ? '0 : rx_cnt + 1'b1;
        end
    end

    // eight-bit frames feed bit 9 directly, so the marker arrives one shift sooner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_sr    <= '1;
            rx_first <= 1'b1;
            rx_noise <= 1'b0;
        end else if (!rx_active || frame_strobe) begin
            rx_sr    <= '1;
            rx_first <= 1'b1;
            if (start_det)
                rx_noise <= 1'b0;
        end else if (shift_bit) begin
            if (nine_mode)
                rx_sr <= {sr_in, rx_sr[`UART_FRAME_W-1:1]};
            else
                rx_sr <= {sr_in, sr_in, rx_sr[`UART_FRAME_W-2:1]};
            rx_noise <= rx_noise | bit_noise | (rx_first & rxd_filt);
            rx_first <= 1'b0;
        end
    end

    // after a bad stop bit wait for a high line before hunting a new start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            hold_idle <= 1'b0;
        else if (frame_strobe && frame_framing)
            hold_idle <= 1'b1;
        else if (sample_hi)
            hold_idle <= 1'b0;
    end

    assign frame_strobe  = rx_active && !rx_sr[0];
    assign frame_bits    = rx_sr[`UART_DATA_W+1:1];
    assign frame_noise   = rx_noise;
    assign frame_framing = nine_mode ? !rx_sr[`UART_FRAME_W-1] : !rx_sr[`UART_FRAME_W-2];
    assign frame_overrun = frame_strobe && stage_full;

endmodule

/* source/uart_rx_queue.sv */
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_rx_queue (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              control,
    input  logic                    frame_strobe,
    input  logic [`UART_DATA_W:0]   frame_bits,
    input  logic                    frame_noise,
    input  logic                    frame_framing,
    input  logic                    frame_overrun,
    input  logic                    read_rx,
    output logic                    stage_full,
    output logic [`UART_DATA_W-1:0] rxdata,
    output logic                    rx_valid,
    output logic [4:0]              rx_status
);

    import uart_ctrl_pkg::*;
    import uart_frame_pkg::*;

    // first stage, straight from the frontend
    logic [`UART_DATA_W:0]   a_bits;
    logic                    a_noise;
    logic                    a_framing;
    logic                    a_overrun;
    logic                    a_valid;

    // second stage, seen by the host
    logic [`UART_DATA_W-1:0] b_data;
    logic [4:0]              b_status;
    logic                    b_valid;

    logic                    parity_bad;
    logic                    keep_char;

    assign parity_bad = rx_parity_bad(control[CTL_MODE_HI:CTL_MODE_LO], a_bits);

    // overrun alone never drops a character
    assign keep_char = hunt_match(control, a_bits[`UART_DATA_W]) &&
                       (!control[CTL_DISCARD] || !(parity_bad || a_noise || a_framing));

    // a strobe now would overwrite a character that cannot move on
    assign stage_full = a_valid && b_valid;

    always_ff @(posedge clk) begin
        if (frame_strobe) begin
            a_bits    <= frame_bits;
            a_noise   <= frame_noise;
            a_framing <= frame_framing;
            a_overrun <= frame_overrun;
        end
        if (a_valid && !b_valid)
            b_data <= a_bits[`UART_DATA_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_valid  <= 1'b0;
            b_valid  <= 1'b0;
            b_status <= '0;
        end else begin
            if (b_valid) begin
                if (read_rx)
                    b_valid <= 1'b0;
            end else if (a_valid) begin
                b_status <= {a_bits[`UART_DATA_W], a_overrun, parity_bad,
                             a_framing, a_noise};
                b_valid  <= keep_char;
                a_valid  <= 1'b0;
            end
            // new character wins over the move out of the first stage
            if (frame_strobe)
                a_valid <= 1'b1;
        end
    end

    assign rxdata    = b_data;
    assign rx_valid  = b_valid;
    assign rx_status = b_status;

endmodule

/* source/uart_tx_engine.sv */
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_tx_engine (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [7:0]              control,
    input  logic [`UART_DIV_W-1:0]  baudrate,
    input  logic [`UART_DATA_W-1:0] txdata,
    input  logic                    write_tx,
    output logic                    txd,
    output logic                    tx_empty,
    output logic                    tx_room
);

    import uart_ctrl_pkg::*;
    import uart_frame_pkg::*;

    logic [`UART_DATA_W-1:0]  a_data;
    logic                     a_valid;
    logic [`UART_DATA_W:0]    b_bits;
    logic                     b_valid;
    logic [`UART_DIV_W-1:0]   tx_cnt;
    logic                     tx_tick;
    logic                     tx_active;
    logic [`UART_FRAME_W-1:0] tx_sr;
    logic                     frame_done;
    logic                     tx_load;

    assign tx_tick = tx_cnt >= baudrate;

    // stop bit has just gone out when only zeros are left above bit 0
    assign frame_done = tx_active && (tx_sr[`UART_FRAME_W-1:1] == '0);
    assign tx_load    = tx_tick && b_valid && control[CTL_TX_EN] &&
                        (!tx_active || frame_done);

    always_ff @(posedge clk) begin
        if (write_tx && !a_valid)
            a_data <= txdata;
        if (a_valid && !b_valid)
            b_bits <= {tx_ninth_bit(control[CTL_MODE_HI:CTL_MODE_LO], a_data,
                                    control[CTL_TX_NINTH]), a_data};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_valid <= 1'b0;
            b_valid <= 1'b0;
        end else begin
            if (write_tx && !a_valid)
                a_valid <= 1'b1;
            if (a_valid && !b_valid) begin
                a_valid <= 1'b0;
                b_valid <= 1'b1;
            end
            if (tx_load)
                b_valid <= 1'b0;
        end
    end

    // free-running, frames start only on its wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tx_cnt <= '0;
        else
            tx_cnt <= tx_tick ? '0 : tx_cnt + 1'b1;
    end

    // top bit is zero in eight-bit mode, the ninth slot then serves as stop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_sr     <= '1;
            tx_active <= 1'b0;
        end else if (tx_load) begin
            tx_sr     <= {nine_bit_mode(control[CTL_MODE_HI:CTL_MODE_LO]), b_bits, 1'b0};
            tx_active <= 1'b1;
        end else if (tx_tick && frame_done) begin
            tx_sr     <= '1;
            tx_active <= 1'b0;
        end else if (tx_tick && tx_active) begin
            tx_sr <= {1'b0, tx_sr[`UART_FRAME_W-1:1]};
        end
    end

    assign txd      = tx_sr[0];
    assign tx_room  = !a_valid;
    assign tx_empty = control[CTL_TX_EN] && !a_valid;

endmodule

/* source/uart_x2.sv */
`timescale 1ns/1ps
`include "uart_cfg.svh"

module uart_x2 (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    rxd,
    input  logic [`UART_DATA_W-1:0] txdata,
    input  logic                    read_rx,
    input  logic                    write_tx,
    input  logic [7:0]              control,
    input  logic [`UART_DIV_W-1:0]  baudrate,
    output logic                    txd,
    output logic [7:0]              status,
    output logic [`UART_DATA_W-1:0] rxdata,
    output logic                    rx_valid,
    output logic                    tx_empty
);

    import uart_ctrl_pkg::*;

    logic                  frame_strobe;
    logic [`UART_DATA_W:0] frame_bits;
    logic                  frame_noise;
    logic                  frame_framing;
    logic                  frame_overrun;
    logic                  stage_full;
    logic [4:0]            rx_status;
    logic                  tx_room;

    uart_rx_frontend i_rx_frontend (
        .clk           (clk),
        .rst_n         (rst_n),
        .rxd           (rxd),
        .control       (control),
        .baudrate      (baudrate),
        .stage_full    (stage_full),
        .frame_strobe  (frame_strobe),
        .frame_bits    (frame_bits),
        .frame_noise   (frame_noise),
        .frame_framing (frame_framing),
        .frame_overrun (frame_overrun)
    );

    uart_rx_queue i_rx_queue (
        .clk           (clk),
        .rst_n         (rst_n),
        .control       (control),
        .frame_strobe  (frame_strobe),
        .frame_bits    (frame_bits),
        .frame_noise   (frame_noise),
        .frame_framing (frame_framing),
        .frame_overrun (frame_overrun),
        .read_rx       (read_rx),
        .stage_full    (stage_full),
        .rxdata        (rxdata),
        .rx_valid      (rx_valid),
        .rx_status     (rx_status)
    );

    uart_tx_engine i_tx_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .control  (control),
        .baudrate (baudrate),
        .txdata   (txdata),
        .write_tx (write_tx),
        .txd      (txd),
        .tx_empty (tx_empty),
        .tx_room  (tx_room)
    );

    // status word, rx_status runs noise up to ninth
    assign status[ST_RX_AVAIL] = rx_valid;
    assign status[ST_TX_ROOM]  = tx_room;
    assign status[ST_NOISE]    = rx_status[0];
    assign status[ST_FRAMING]  = rx_status[1];
    assign status[ST_PARITY]   = rx_status[2];
    assign status[ST_OVERRUN]  = rx_status[3];
    assign status[ST_NINTH]    = rx_status[4];
    assign status[7]           = 1'b0;

endmodule

/* dv/tb_uart_x2.sv */
`timescale 1ns/1ps
`include "uart_cfg.svh"

module tb_uart_x2;

    import uart_ctrl_pkg::*;

    localparam int BIT_CLKS = 16;
    localparam int N_FRAMES = 64;
    // frames times 12 bits times the bit length in ns with a threefold margin
    localparam int LIMIT_NS = N_FRAMES * 12 * BIT_CLKS * 4 * 3;

    logic                   clk;
    logic                   rst_n;
    logic                   rxd;
    logic                   read_rx;
    logic                   write_tx;
    logic [7:0]             txdata;
    logic [7:0]             control;
    logic [`UART_DIV_W-1:0] baudrate;
    logic                   txd;
    logic [7:0]             status;
    logic [7:0]             rxdata;
    logic                   rx_valid;
    logic                   tx_empty;

    logic [15:0] lfsr_state;
    int          errors;
    int          test_errors;
    int          tests_run;
    logic [7:0]  exp_data[$];
    logic        exp_slot[$];
    bit          writes_done;

    uart_x2 i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (rxd),
        .txdata   (txdata),
        .read_rx  (read_rx),
        .write_tx (write_tx),
        .control  (control),
        .baudrate (baudrate),
        .txd      (txd),
        .status   (status),
        .rxdata   (rxdata),
        .rx_valid (rx_valid),
        .tx_empty (tx_empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        $display("timeout: the run did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

    // taps 16, 14, 13, 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] v;
        for (int i = 0; i < 8; i++)
            v[i] = lfsr_bit();
        return v;
    endfunction

    // result is {parity error, ninth bit}
    // ninth_in is the received ninth bit or the transmit control bit
    function automatic logic [1:0] expect_frame(input logic [1:0] mode, input logic [7:0] data,
                                                input logic ninth_in);
        int   ones;
        logic ninth;
        ones = 0;
        for (int i = 0; i < 8; i++)
            ones += data[i];
        case (mode)
            MODE_EIGHT: ninth = 1'b1;
            MODE_ODD:   ninth = (ones % 2 == 0);
            MODE_EVEN:  ninth = (ones % 2 == 1);
            default:    ninth = ninth_in;
        endcase
        return {(mode == MODE_ODD || mode == MODE_EVEN) && (ninth_in != ninth), ninth};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // serial line model for rxd with one bit per BIT_CLKS clocks
    task automatic send_frame(input logic [7:0] data, input logic ninth, input logic bad_stop);
        logic [10:0] bits;
        int          n;
        n = (control[CTL_MODE_HI:CTL_MODE_LO] == MODE_EIGHT) ? 10 : 11;
        bits = (n == 10) ? {2'b11, data, 1'b0} : {1'b1, ninth, data, 1'b0};
        bits[n-1] = !bad_stop;
        @(negedge clk);
        for (int i = 0; i < n; i++) begin
            rxd = bits[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rxd = 1'b1;
        repeat (2 * BIT_CLKS) @(negedge clk);
    endtask

    task automatic wait_valid(input int limit, output bit seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (n < limit && !seen) begin
            @(negedge clk);
            seen = rx_valid;
            n++;
        end
    endtask

    task automatic read_char();
        @(negedge clk);
        read_rx = 1'b1;
        @(negedge clk);
        read_rx = 1'b0;
    endtask

    // exp_err is {overrun, parity, framing, noise}
    task automatic take_char(input logic [7:0] data, input logic ninth, input bit keep,
                             input logic [3:0] exp_err, input bit check_ninth);
        bit seen;
        wait_valid(2 * BIT_CLKS, seen);
        if (!keep) begin
            if (seen) begin
                $display("a character was delivered that should have been dropped");
                errors++;
                read_char();
            end
        end else if (!seen) begin
            $display("no character arrived on the receive side");
            errors++;
        end else begin
            check_val("rxdata", rxdata, data);
            check_val("status[5:2]", status[5:2], exp_err);
            if (check_ninth)
                check_val("status[6]", status[6], ninth);
            read_char();
        end
    endtask

    task automatic rx_case(input logic [7:0] data, input logic ninth, input logic bad_stop,
                           input bit keep, input logic [3:0] exp_err, input bit check_ninth);
        send_frame(data, ninth, bad_stop);
        take_char(data, ninth, keep, exp_err, check_ninth);
    endtask

    // writes n bytes either when room shows or blindly on every cycle
    // the second branch watches txd
    task automatic tx_run(input int n, input bit wait_room);
        logic [7:0] d;
        logic [9:0] got;
        logic [7:0] e_data;
        logic       e_slot;
        logic [1:0] ef;
        int         nbits;
        writes_done = 1'b0;
        // eight-bit frames end with the ninth slot as their stop bit
        nbits = (control[CTL_MODE_HI:CTL_MODE_LO] == MODE_EIGHT) ? 9 : 10;
        @(negedge clk);
        fork
            begin
                for (int k = 0; k < n; k++) begin
                    while (wait_room && !status[ST_TX_ROOM])
                        @(negedge clk);
                    d = rand_byte();
                    txdata = d;
                    write_tx = 1'b1;
                    if (status[ST_TX_ROOM]) begin
                        ef = expect_frame(control[1:0], d, control[CTL_TX_NINTH]);
                        exp_data.push_back(d);
                        exp_slot.push_back(ef[0]);
                    end
                    @(negedge clk);
                    write_tx = 1'b0;
                end
                writes_done = 1'b1;
            end
            while (!writes_done || exp_data.size() > 0) begin
                @(negedge txd);
                repeat (BIT_CLKS / 2) @(negedge clk);
                check_val("txd start", txd, 1'b0);
                for (int i = 0; i < nbits; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    got[i] = txd;
                end
                if (exp_data.size() == 0) begin
                    $display("a frame appeared on txd that was never written");
                    errors++;
                end else begin
                    e_data = exp_data.pop_front();
                    e_slot = exp_slot.pop_front();
                    check_val("txd data", got[7:0], e_data);
                    check_val("txd ninth slot", got[8], e_slot);
                    if (nbits == 10)
                        check_val("txd stop", got[9], 1'b1);
                end
            end
        join
    endtask

    task automatic end_test(input string name);
        $display("%s: %s", name, (errors == test_errors) ? "ok" : "failed");
        tests_run++;
        test_errors = errors;
    endtask

    initial begin
        logic [7:0] d;
        logic [7:0] d1;
        logic [7:0] d3;
        logic [1:0] e;
        logic       nb;
        rxd = 1'b1;
        read_rx = 1'b0;
        write_tx = 1'b0;
        txdata = 8'h00;
        control = 8'h50;
        baudrate = BIT_CLKS - 1;
        rst_n = 1'b0;
        lfsr_state = 16'd48309;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_val("txd", txd, 1'b1);
        check_val("rx_valid", rx_valid, 1'b0);
        check_val("status", status & 8'hfd, 8'h00);
        check_val("tx_empty", tx_empty, control[CTL_TX_EN]);
        end_test("reset values");

        for (int k = 0; k < 16; k++)
            rx_case(rand_byte(), 1'b1, 1'b0, 1'b1, 4'b0000, 1'b0);
        tx_run(16, 1'b1);
        end_test("eight-bit receive and transmit");

        for (int m = 1; m <= 2; m++) begin
            control = 8'h50 | m[7:0];
            tx_run(1, 1'b1);
            d = rand_byte();
            e = expect_frame(m[1:0], d, 1'b0);
            nb = e[0];
            rx_case(d, nb, 1'b0, 1'b1, 4'b0000, 1'b0);
            e = expect_frame(m[1:0], d, !nb);
            rx_case(d, !nb, 1'b0, 1'b1, {1'b0, e[1], 2'b00}, 1'b0);
        end
        end_test("odd and even parity");

        control = 8'h59;
        d = rand_byte();
        e = expect_frame(MODE_ODD, d, 1'b0);
        rx_case(d, !e[0], 1'b0, 1'b0, 4'b0000, 1'b0);
        d = rand_byte();
        e = expect_frame(MODE_ODD, d, 1'b0);
        rx_case(d, e[0], 1'b1, 1'b0, 4'b0000, 1'b0);
        d = rand_byte();
        e = expect_frame(MODE_ODD, d, 1'b0);
        rx_case(d, e[0], 1'b0, 1'b1, 4'b0000, 1'b0);
        end_test("discard");

        // hunting for ninth bit zero, then for ninth bit one
        for (int hv = 0; hv < 2; hv++) begin
            control = (hv == 0) ? 8'h73 : 8'h77;
            for (int k = 0; k < 4; k++) begin
                nb = k[0];
                rx_case(rand_byte(), nb, 1'b0, nb == control[CTL_HUNT_VAL], 4'b0000, 1'b1);
            end
        end
        end_test("address hunt");

        control = 8'h50;
        d1 = rand_byte();
        d3 = rand_byte();
        send_frame(d1, 1'b1, 1'b0);
        send_frame(rand_byte(), 1'b1, 1'b0);
        send_frame(d3, 1'b1, 1'b0);
        take_char(d1, 1'b1, 1'b1, 4'b0000, 1'b0);
        take_char(d3, 1'b1, 1'b1, 4'b1000, 1'b0);
        take_char(8'h00, 1'b0, 1'b0, 4'b0000, 1'b0);
        end_test("overrun");

        tx_run(6, 1'b0);
        end_test("transmit back-pressure");

        $display("%0d tests run, %0d errors", tests_run, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* all.f */
+incdir+source
source/uart_ctrl_pkg.sv
source/uart_frame_pkg.sv
source/uart_rx_frontend.sv
source/uart_rx_queue.sv
source/uart_tx_engine.sv
source/uart_x2.sv
dv/tb_uart_x2.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_uart_x2 -o sim_uart_x2
./obj_dir/sim_uart_x2 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
